// File: hdl/cnn_mac_pkg.sv
// convolution subunit shared types
`default_nettype none

package cnn_mac_pkg;

	// array and storage sizes
	localparam int NUM_LANES = 8;
	localparam int ACT_DEPTH = 32;
	localparam int POOL_DEPTH = 16;

	// operand widths
	localparam int ACT_W = 8;
	localparam int WEIGHT_W = 8;
	localparam int ZP_W = 8;

	// accumulator width wrapping modulo 2**24
	localparam int ACC_W = 24;

	// index widths follow the sizes above
	localparam int ACT_ADDR_W = $clog2(ACT_DEPTH);
	localparam int POOL_ADDR_W = $clog2(POOL_DEPTH);
	localparam int LANE_IDX_W = $clog2(NUM_LANES);

	// unsigned 8-bit activation
	typedef logic [ACT_W-1:0] act_t;
	// unsigned 8-bit weight
	typedef logic [WEIGHT_W-1:0] weight_t;
	// weight zero point for the offset correction
	typedef logic [ZP_W-1:0] zero_point_t;

	// activation buffer address
	typedef logic [ACT_ADDR_W-1:0] act_addr_t;
	// weight pool index, one per iteration
	typedef logic [POOL_ADDR_W-1:0] pool_addr_t;
	// lane number on the weight write port
	typedef logic [LANE_IDX_W-1:0] lane_idx_t;
	// one enable bit per lane
	typedef logic [NUM_LANES-1:0] lane_mask_t;

	// accumulator and result value
	typedef logic [ACC_W-1:0] acc_t;

	// lane 0 in the low byte
	typedef logic [NUM_LANES*WEIGHT_W-1:0] weight_vec_t;
	// lane 0 in the low 24 bits
	typedef logic [NUM_LANES*ACC_W-1:0] result_vec_t;

endpackage

`default_nettype wire

// File: hdl/act_fetch.sv
// activation buffer with step read
`timescale 1ns/100ps
`default_nettype none

module act_fetch (
	input  logic                   clk,
	input  logic                   rst_n_i,
	// host write port
	input  logic                   act_wr_en_i,
	input  cnn_mac_pkg::act_addr_t act_wr_addr_i,
	input  cnn_mac_pkg::act_t      act_wr_data_i,
	// step read request
	input  logic                   step_i,
	input  cnn_mac_pkg::act_addr_t act_rd_addr_i,
	// towards the mac array
	output cnn_mac_pkg::act_t      act_o,
	output logic                   act_nz_o
);

	import cnn_mac_pkg::*;

	// single activation buffer
	act_t act_mem [ACT_DEPTH];

	// addressed entry before the read register
	act_t rd_act;
	logic rd_nz;

	// host writes one entry per cycle
	always_ff @(posedge clk) begin
		if (act_wr_en_i) begin
			act_mem[act_wr_addr_i] <= act_wr_data_i;
		end
	end

	assign rd_act = act_mem[act_rd_addr_i];

	// zero skipping is decided here only
	assign rd_nz = |rd_act;

	// activation register loaded only on a step
	// mac array ignores it unless act_nz_o is set
	always_ff @(posedge clk) begin
		if (step_i) begin
			act_o <= rd_act;
		end
	end

	// one cycle pulse per fetched nonzero activation
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			act_nz_o <= 1'b0;
		end else begin
			act_nz_o <= step_i & rd_nz;
		end
	end

endmodule

`default_nettype wire

// File: hdl/weight_pool.sv
// per-lane weight pools
`timescale 1ns/100ps
`default_nettype none

module weight_pool (
	input  logic                    clk,
	input  logic                    rst_n_i,
	// host write port for one lane at a time
	input  logic                    wt_wr_en_i,
	input  cnn_mac_pkg::lane_idx_t  wt_wr_lane_i,
	input  cnn_mac_pkg::pool_addr_t wt_wr_addr_i,
	input  cnn_mac_pkg::weight_t    wt_wr_data_i,
	// step read request
	input  logic                    step_i,
	input  cnn_mac_pkg::pool_addr_t iter_i,
	input  cnn_mac_pkg::lane_mask_t lane_en_i,
	// towards the mac array
	output cnn_mac_pkg::weight_vec_t weights_o,
	output cnn_mac_pkg::lane_mask_t lane_en_o
);

	import cnn_mac_pkg::*;

	// one pool per lane indexed by iteration
	weight_t pool_mem [NUM_LANES][POOL_DEPTH];

	// mask gated by the step
	lane_mask_t step_mask;

	// host writes land in the selected lane only
	always_ff @(posedge clk) begin
		if (wt_wr_en_i) begin
			pool_mem[wt_wr_lane_i][wt_wr_addr_i] <= wt_wr_data_i;
		end
	end

	// all lanes read the same iteration on a step
	// lane l goes to byte l of the vector
	always_ff @(posedge clk) begin
		if (step_i) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				weights_o[l*WEIGHT_W +: WEIGHT_W] <= pool_mem[l][iter_i];
			end
		end
	end

	// all zero when no step is issued
	assign step_mask = step_i ? lane_en_i : '0;

	// registered with the weights so both arrive together
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			lane_en_o <= '0;
		end else begin
			lane_en_o <= step_mask;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mac_array.sv
// mac lanes with offset correction
`timescale 1ns/100ps
`default_nettype none

module mac_array (
	input  logic                     clk,
	input  logic                     rst_n_i,
	// shared activation already zero checked
	input  cnn_mac_pkg::act_t        act_i,
	input  logic                     act_nz_i,
	// per-lane weights and enables
	input  cnn_mac_pkg::weight_vec_t weights_i,
	input  cnn_mac_pkg::lane_mask_t  lane_en_i,
	// stage finish and quantization setup
	input  logic                     finish_i,
	input  logic                     quant_en_i,
	input  cnn_mac_pkg::zero_point_t zero_point_i,
	// stage results
	output cnn_mac_pkg::result_vec_t results_o,
	output logic                     result_valid_o
);

	import cnn_mac_pkg::*;

	// lane accumulators
	acc_t acc_q [NUM_LANES];
	// running sum of accumulated activations
	acc_t act_sum_q;

	// lane products widened before the multiply
	acc_t prod [NUM_LANES];

	// finish aligned with the last accumulate
	logic finish_q;

	// zero point times activation sum
	acc_t zp_offset;

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			prod[l] = acc_t'(act_i) * acc_t'(weights_i[l*WEIGHT_W +: WEIGHT_W]);
		end
	end

	// wraps modulo 2**24 like the accumulators
	assign zp_offset = acc_t'(zero_point_i) * act_sum_q;

	// a step sampled one edge before finish lands on the next edge
	// so results taken one edge later include it
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			finish_q <= 1'b0;
		end else begin
			finish_q <= finish_i;
		end
	end

	// accumulate on nonzero steps and clear when results are taken
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				acc_q[l] <= '0;
			end
			act_sum_q <= '0;
		end else if (finish_q) begin
			// next stage starts from zero
			for (int l = 0; l < NUM_LANES; l++) begin
				acc_q[l] <= '0;
			end
			act_sum_q <= '0;
		end else if (act_nz_i) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (lane_en_i[l]) begin
					acc_q[l] <= acc_q[l] + prod[l];
				end
			end
			// counted once per step regardless of the mask
			act_sum_q <= act_sum_q + acc_t'(act_i);
		end
	end

	// result registers with all lanes corrected when quantized
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			results_o <= '0;
		end else if (finish_q) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (quant_en_i) begin
					results_o[l*ACC_W +: ACC_W] <= acc_q[l] - zp_offset;
				end else begin
					results_o[l*ACC_W +: ACC_W] <= acc_q[l];
				end
			end
		end
	end

	// valid for one cycle alongside fresh results
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= finish_q;
		end
	end

endmodule

`default_nettype wire

// File: hdl/cnn_mac_subunit.sv
// convolution mac subunit top
`timescale 1ns/100ps
`default_nettype none

module cnn_mac_subunit (
	input  logic                     clk,
	input  logic                     rst_n_i,
	// activation buffer writes
	input  logic                     act_wr_en_i,
	input  cnn_mac_pkg::act_addr_t   act_wr_addr_i,
	input  cnn_mac_pkg::act_t        act_wr_data_i,
	// weight pool writes
	input  logic                     wt_wr_en_i,
	input  cnn_mac_pkg::lane_idx_t   wt_wr_lane_i,
	input  cnn_mac_pkg::pool_addr_t  wt_wr_addr_i,
	input  cnn_mac_pkg::weight_t     wt_wr_data_i,
	// step strobe with its operands
	input  logic                     step_i,
	input  cnn_mac_pkg::act_addr_t   act_rd_addr_i,
	input  cnn_mac_pkg::pool_addr_t  iter_i,
	input  cnn_mac_pkg::lane_mask_t  lane_en_i,
	// stage finish
	input  logic                     finish_i,
	input  logic                     quant_en_i,
	input  cnn_mac_pkg::zero_point_t zero_point_i,
	// stage results
	output cnn_mac_pkg::result_vec_t results_o,
	output logic                     result_valid_o
);

	import cnn_mac_pkg::*;

	// activation path outputs
	act_t act;
	logic act_nz;

	// weight path outputs
	weight_vec_t weights;
	lane_mask_t lane_en;

	// activation path with one read per step
	act_fetch act_fetch_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.act_wr_en_i   (act_wr_en_i),
		.act_wr_addr_i (act_wr_addr_i),
		.act_wr_data_i (act_wr_data_i),
		.step_i        (step_i),
		.act_rd_addr_i (act_rd_addr_i),
		.act_o         (act),
		.act_nz_o      (act_nz)
	);

	// weight path reading all lanes in parallel
	weight_pool weight_pool_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.wt_wr_en_i   (wt_wr_en_i),
		.wt_wr_lane_i (wt_wr_lane_i),
		.wt_wr_addr_i (wt_wr_addr_i),
		.wt_wr_data_i (wt_wr_data_i),
		.step_i       (step_i),
		.iter_i       (iter_i),
		.lane_en_i    (lane_en_i),
		.weights_o    (weights),
		.lane_en_o    (lane_en)
	);

	// both paths arrive one cycle after the step
	mac_array mac_array_i (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.act_i          (act),
		.act_nz_i       (act_nz),
		.weights_i      (weights),
		.lane_en_i      (lane_en),
		.finish_i       (finish_i),
		.quant_en_i     (quant_en_i),
		.zero_point_i   (zero_point_i),
		.results_o      (results_o),
		.result_valid_o (result_valid_o)
	);

endmodule

`default_nettype wire

// File: test/tb_vectors.svh
// mac subunit stimulus table
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int MAX_STEPS = 8;
localparam int NUM_TESTS = 8;

// one stage per row with expected results from the reference model
typedef struct {
	string       name;
	int          num_steps;
	act_addr_t   addr [MAX_STEPS];
	pool_addr_t  iter [MAX_STEPS];
	lane_mask_t  mask [MAX_STEPS];
	logic        quant_en;
	zero_point_t zp;
	acc_t        expected [NUM_LANES];
} test_row_t;

test_row_t tests [NUM_TESTS];

// start a row with its finish setup
task automatic open_row(input int idx, input string name, input logic quant_en,
	input zero_point_t zp);
	tests[idx].name = name;
	tests[idx].num_steps = 0;
	tests[idx].quant_en = quant_en;
	tests[idx].zp = zp;
	for (int l = 0; l < NUM_LANES; l++) begin
		tests[idx].expected[l] = '0;
	end
endtask

// append one step to a row
task automatic add_step(input int idx, input act_addr_t addr, input pool_addr_t iter,
	input lane_mask_t mask);
	int s;
	s = tests[idx].num_steps;
	tests[idx].addr[s] = addr;
	tests[idx].iter[s] = iter;
	tests[idx].mask[s] = mask;
	tests[idx].num_steps = s + 1;
endtask

// buffer entries 24 to 27 hold zero activations
task automatic fill_table();
	// all lanes over eight back-to-back steps
	open_row(0, "plain_accum", 1'b0, 8'h00);
	for (int s = 0; s < MAX_STEPS; s++) begin
		add_step(0, act_addr_t'(s), pool_addr_t'(s), 8'hff);
	end
	// lane 7 is never enabled
	open_row(1, "lane_mask", 1'b0, 8'h00);
	add_step(1, 5'd8, 4'd0, 8'h7f);
	add_step(1, 5'd9, 4'd1, 8'h0f);
	add_step(1, 5'd10, 4'd2, 8'h55);
	add_step(1, 5'd11, 4'd3, 8'h33);
	add_step(1, 5'd12, 4'd4, 8'h01);
	add_step(1, 5'd13, 4'd5, 8'h7e);
	// zero steps mixed in
	open_row(2, "zero_skip", 1'b0, 8'h00);
	add_step(2, 5'd1, 4'd2, 8'hff);
	add_step(2, 5'd24, 4'd3, 8'hff);
	add_step(2, 5'd2, 4'd4, 8'hff);
	add_step(2, 5'd25, 4'd5, 8'hf0);
	add_step(2, 5'd3, 4'd6, 8'hff);
	add_step(2, 5'd26, 4'd7, 8'hff);
	// same stage as row 2 with the zero steps removed
	open_row(3, "zero_skip_ref", 1'b0, 8'h00);
	add_step(3, 5'd1, 4'd2, 8'hff);
	add_step(3, 5'd2, 4'd4, 8'hff);
	add_step(3, 5'd3, 4'd6, 8'hff);
	open_row(4, "quant_offset", 1'b1, 8'h80);
	for (int s = 0; s < 6; s++) begin
		add_step(4, act_addr_t'(14 + s), pool_addr_t'(8 + s), 8'hff);
	end
	// masked lanes still get the offset
	open_row(5, "quant_masked", 1'b1, 8'hff);
	add_step(5, 5'd20, 4'd14, 8'h0f);
	add_step(5, 5'd27, 4'd15, 8'hff);
	add_step(5, 5'd21, 4'd15, 8'hf0);
	add_step(5, 5'd22, 4'd0, 8'h3c);
	// two stages in a row
	open_row(6, "stage_a", 1'b0, 8'h00);
	for (int s = 0; s < MAX_STEPS; s++) begin
		add_step(6, 5'd23, pool_addr_t'(s), 8'hff);
	end
	open_row(7, "stage_b", 1'b1, 8'h01);
	add_step(7, 5'd28, 4'd9, 8'haa);
	add_step(7, 5'd29, 4'd10, 8'h55);
	add_step(7, 5'd30, 4'd11, 8'hff);
	add_step(7, 5'd31, 4'd12, 8'h81);
endtask

`endif

// File: test/tb_cnn_mac_subunit.sv
// mac subunit testbench
`timescale 1ns/100ps
`default_nettype none

module tb_cnn_mac_subunit;

	import cnn_mac_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int SEED = 90;
	localparam int TIMEOUT_CYCLES = 20;
	// edges from finish sampled to result_valid_o
	localparam int FINISH_LATENCY = 2;
	// buffer range written with zero activations
	localparam int ZERO_FIRST = 24;
	localparam int ZERO_LAST = 27;

	logic clk;
	logic rst_n_i;
	logic act_wr_en_i;
	act_addr_t act_wr_addr_i;
	act_t act_wr_data_i;
	logic wt_wr_en_i;
	lane_idx_t wt_wr_lane_i;
	pool_addr_t wt_wr_addr_i;
	weight_t wt_wr_data_i;
	logic step_i;
	act_addr_t act_rd_addr_i;
	pool_addr_t iter_i;
	lane_mask_t lane_en_i;
	logic finish_i;
	logic quant_en_i;
	zero_point_t zero_point_i;
	result_vec_t results_o;
	logic result_valid_o;

	// own copies of buffer and pools
	act_t act_copy [ACT_DEPTH];
	weight_t wt_copy [NUM_LANES][POOL_DEPTH];

	integer seed;
	int error_count;
	int test_errors;
	int tests_failed;
	bit timed_out;

	`include "tb_vectors.svh"

	cnn_mac_subunit dut_i (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.act_wr_en_i    (act_wr_en_i),
		.act_wr_addr_i  (act_wr_addr_i),
		.act_wr_data_i  (act_wr_data_i),
		.wt_wr_en_i     (wt_wr_en_i),
		.wt_wr_lane_i   (wt_wr_lane_i),
		.wt_wr_addr_i   (wt_wr_addr_i),
		.wt_wr_data_i   (wt_wr_data_i),
		.step_i         (step_i),
		.act_rd_addr_i  (act_rd_addr_i),
		.iter_i         (iter_i),
		.lane_en_i      (lane_en_i),
		.finish_i       (finish_i),
		.quant_en_i     (quant_en_i),
		.zero_point_i   (zero_point_i),
		.results_o      (results_o),
		.result_valid_o (result_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string sig, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", sig, actual, expected);
			error_count++;
			test_errors++;
		end
	endtask

	// random nonzero activations outside the zero range and random weights
	task automatic load_memories();
		logic [31:0] rnd;
		for (int a = 0; a < ACT_DEPTH; a++) begin
			rnd = $random(seed);
			@(negedge clk);
			check_value("result_valid_o", 32'(result_valid_o), 32'h0);
			act_copy[a] = (a >= ZERO_FIRST && a <= ZERO_LAST) ? 8'h00 : (rnd[7:0] | 8'h01);
			act_wr_en_i = 1'b1;
			act_wr_addr_i = act_addr_t'(a);
			act_wr_data_i = act_copy[a];
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int i = 0; i < POOL_DEPTH; i++) begin
				rnd = $random(seed);
				@(negedge clk);
				check_value("result_valid_o", 32'(result_valid_o), 32'h0);
				act_wr_en_i = 1'b0;
				wt_copy[l][i] = rnd[7:0];
				wt_wr_en_i = 1'b1;
				wt_wr_lane_i = lane_idx_t'(l);
				wt_wr_addr_i = pool_addr_t'(i);
				wt_wr_data_i = rnd[7:0];
			end
		end
		@(negedge clk);
		wt_wr_en_i = 1'b0;
	endtask

	// reference model skipping zero steps and wrapping at 24 bits
	task automatic compute_expected(input int idx);
		acc_t acc [NUM_LANES];
		acc_t act_sum;
		act_t a;
		for (int l = 0; l < NUM_LANES; l++) begin
			acc[l] = '0;
		end
		act_sum = '0;
		for (int s = 0; s < tests[idx].num_steps; s++) begin
			a = act_copy[tests[idx].addr[s]];
			if (a != 8'h00) begin
				act_sum = act_sum + acc_t'(a);
				for (int l = 0; l < NUM_LANES; l++) begin
					if (tests[idx].mask[s][l]) begin
						acc[l] = acc[l] + acc_t'(a) * acc_t'(wt_copy[l][tests[idx].iter[s]]);
					end
				end
			end
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (tests[idx].quant_en) begin
				tests[idx].expected[l] = acc[l] - acc_t'(tests[idx].zp) * act_sum;
			end else begin
				tests[idx].expected[l] = acc[l];
			end
		end
	endtask

	task automatic run_test(input int idx);
		int cycles;
		bit seen;
		test_errors = 0;
		// held until result_valid_o
		quant_en_i = tests[idx].quant_en;
		zero_point_i = tests[idx].zp;
		for (int s = 0; s < tests[idx].num_steps; s++) begin
			@(negedge clk);
			step_i = 1'b1;
			act_rd_addr_i = tests[idx].addr[s];
			iter_i = tests[idx].iter[s];
			lane_en_i = tests[idx].mask[s];
		end
		@(negedge clk);
		step_i = 1'b0;
		lane_en_i = '0;
		@(negedge clk);
		@(negedge clk);
		finish_i = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			finish_i = 1'b0;
			cycles++;
			seen = result_valid_o;
		end
		if (!seen) begin
			$display("timeout in test %0d: result_valid_o never rose after finish_i", idx);
			timed_out = 1'b1;
			error_count++;
			test_errors++;
		end else begin
			check_value("result_latency", 32'(cycles), 32'(FINISH_LATENCY));
			for (int l = 0; l < NUM_LANES; l++) begin
				check_value($sformatf("results_o[lane %0d]", l),
					32'(results_o[l*ACC_W +: ACC_W]), 32'(tests[idx].expected[l]));
			end
			// one cycle pulse only
			@(negedge clk);
			check_value("result_valid_o", 32'(result_valid_o), 32'h0);
		end
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("test %0d %-14s %s", idx, tests[idx].name,
			(test_errors == 0) ? "ok" : "FAILED");
	endtask

	initial begin
		seed = SEED;
		error_count = 0;
		test_errors = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		rst_n_i = 1'b0;
		act_wr_en_i = 1'b0;
		act_wr_addr_i = '0;
		act_wr_data_i = '0;
		wt_wr_en_i = 1'b0;
		wt_wr_lane_i = '0;
		wt_wr_addr_i = '0;
		wt_wr_data_i = '0;
		step_i = 1'b0;
		act_rd_addr_i = '0;
		iter_i = '0;
		lane_en_i = '0;
		finish_i = 1'b0;
		quant_en_i = 1'b0;
		zero_point_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		// reset values
		check_value("result_valid_o", 32'(result_valid_o), 32'h0);
		for (int l = 0; l < NUM_LANES; l++) begin
			check_value($sformatf("results_o[lane %0d]", l),
				32'(results_o[l*ACC_W +: ACC_W]), 32'h0);
		end
		fill_table();
		load_memories();
		for (int t = 0; t < NUM_TESTS; t++) begin
			compute_expected(t);
		end
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			run_test(t);
		end
		$display("tests %0d, tests with errors %0d, check errors %0d",
			NUM_TESTS, tests_failed, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+test
hdl/cnn_mac_pkg.sv
hdl/act_fetch.sv
hdl/weight_pool.sv
hdl/mac_array.sv
hdl/cnn_mac_subunit.sv
test/tb_cnn_mac_subunit.sv

// File: run.sh
#!/bin/sh
# build and run the mac subunit testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_cnn_mac_subunit -o tb_sim \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All tests passed" && exit 0 || exit 1
